//--- list.f
+incdir+bench
source/axi4s_pkg.sv
source/path_pkg.sv
source/stream_if.sv
source/stream_fwd_stage.sv
source/stream_ready_skid.sv
source/tlast_advancer.sv
source/packet_counter.sv
source/path_select_fsm.sv
source/stream_path_top.sv
bench/tb_stream_path.sv

//--- Bender.yml
package:
  name: stream_path

sources:
  - files:
      - source/axi4s_pkg.sv
      - source/path_pkg.sv
      - source/stream_if.sv
      - source/stream_fwd_stage.sv
      - source/stream_ready_skid.sv
      - source/tlast_advancer.sv
      - source/packet_counter.sv
      - source/path_select_fsm.sv
      - source/stream_path_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_stream_path.sv

//--- bench/tb_stream_model.svh
`ifndef TB_STREAM_MODEL_SVH
`define TB_STREAM_MODEL_SVH

// Stimulus for all tests in send order
tdata_t stim_data [$];
tkeep_t stim_keep [$];
logic   stim_last [$];
int     test_beats [2:6];

// Expected dst beats with the oldest first
tdata_t exp_data [$];
tkeep_t exp_keep [$];
logic   exp_last [$];
int     pkts_exp = 0;

// Model state of the open input packet
logic   pkt_open = 1'b0;
logic   pkt_bypass = 1'b0;
logic   pend_valid = 1'b0;
tdata_t pend_data;
tkeep_t pend_keep;

logic [31:0] lcg_state = 32'd9309;

// Low LCG bits repeat quickly so only the upper half is returned
function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

function automatic void push_expected(input tdata_t data, input tkeep_t keep, input logic last);
    exp_data.push_back(data);
    exp_keep.push_back(keep);
    exp_last.push_back(last);
endfunction

// 1 to 8 beats with nonzero keep and sometimes an empty last beat after them
function automatic void gen_packets(input int test, input int n_pkts, input logic empty_ok);
    int     len;
    logic   add_empty;
    tkeep_t keep;
    for (int p = 0; p < n_pkts; p++) begin
        len = 1 + int'(rand16() % 16'd8);
        add_empty = empty_ok && (rand16() % 16'd3 == 0);
        for (int b = 0; b < len; b++) begin
            keep = tkeep_t'(rand16());
            if (keep == '0) begin
                keep = '1;
            end
            stim_data.push_back({rand16(), rand16()});
            stim_keep.push_back(keep);
            stim_last.push_back(!add_empty && (b == len - 1));
        end
        if (add_empty) begin
            stim_data.push_back({rand16(), rand16()});
            stim_keep.push_back('0);
            stim_last.push_back(1'b1);
        end
        test_beats[test] += len + int'(add_empty);
    end
endfunction

// Processed packets lose an empty last beat and tlast moves onto the beat before
function automatic void model_accept(input tdata_t data, input tkeep_t keep,
                                     input logic last, input logic byp);
    if (!pkt_open) begin
        pkt_bypass = byp;
    end
    pkt_open = !last;
    if (last) begin
        pkts_exp++;
    end
    if (pkt_bypass) begin
        push_expected(data, keep, last);
    end else if (last && keep == '0) begin
        push_expected(pend_data, pend_keep, 1'b1);
        pend_valid = 1'b0;
    end else begin
        if (pend_valid) begin
            push_expected(pend_data, pend_keep, 1'b0);
        end
        pend_data  = data;
        pend_keep  = keep;
        pend_valid = !last;
        if (last) begin
            push_expected(data, keep, 1'b1);
        end
    end
endfunction

`endif

//--- bench/tb_stream_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_path
    import axi4s_pkg::*;
;

    localparam int PKTS_PER_TEST = 30;

    logic   axi4s_if_from_tx;
    logic   aresetn;
    logic   bypass_req;
    logic   src_tvalid;
    logic   src_tready;
    tdata_t src_tdata;
    tkeep_t src_tkeep;
    logic   src_tlast;
    logic   dst_tvalid;
    logic   dst_tready;
    tdata_t dst_tdata;
    tkeep_t dst_tkeep;
    logic   dst_tlast;
    logic   bypass_active;

    int   errors = 0;
    int   checks = 0;
    int   pkts_out = 0;
    int   total_beats = 0;
    int   ready_mode = 0;
    int   stall_left = 0;
    logic toggle_en = 1'b0;
    logic saw_src_stall = 1'b0;
    logic saw_switch = 1'b0;
    logic prev_active = 1'b0;

    `include "tb_stream_model.svh"

    stream_path_top stream_path_top_inst (.*);

    initial begin
        axi4s_if_from_tx = 1'b0;
        forever begin
            #5 axi4s_if_from_tx = ~axi4s_if_from_tx;
        end
    end

    // Back-pressure mode 0 is always ready, 1 random and 2 random with long stalls
    always @(posedge axi4s_if_from_tx) begin
        if (stall_left > 0) begin
            stall_left <= stall_left - 1;
            dst_tready <= 1'b0;
        end else if (ready_mode == 2 && rand16() % 16'd32 == 0) begin
            stall_left <= 20 + int'(rand16() % 16'd20);
            dst_tready <= 1'b0;
        end else begin
            dst_tready <= (ready_mode == 0) || (rand16() % 16'd4 != 0);
        end
        if (toggle_en && rand16() % 16'd24 == 0) begin
            bypass_req <= !bypass_req;
        end
    end

    task automatic check_beat();
        checks++;
        assert (exp_data.size() > 0) else begin
            $display("Beat on dst while no beat was expected");
            errors++;
        end
        if (exp_data.size() > 0) begin
            assert (dst_tdata == exp_data[0]) else begin
                $display("ERROR dst_tdata expected %h got %h", exp_data[0], dst_tdata);
                errors++;
            end
            assert (dst_tkeep == exp_keep[0]) else begin
                $display("ERROR dst_tkeep expected %h got %h", exp_keep[0], dst_tkeep);
                errors++;
            end
            assert (dst_tlast == exp_last[0]) else begin
                $display("ERROR dst_tlast expected %h got %h", exp_last[0], dst_tlast);
                errors++;
            end
            exp_data.delete(0);
            exp_keep.delete(0);
            exp_last.delete(0);
        end
        pkts_out += int'(dst_tlast);
    endtask

    always @(posedge axi4s_if_from_tx) begin
        if (aresetn) begin
            if (src_tvalid && src_tready) begin
                model_accept(src_tdata, src_tkeep, src_tlast, bypass_active);
            end
            if (dst_tvalid && dst_tready) begin
                check_beat();
            end
            if (stall_left > 0 && src_tvalid && !src_tready && bypass_req == bypass_active) begin
                saw_src_stall = 1'b1;
            end
            saw_switch |= (bypass_active != prev_active);
            prev_active = bypass_active;
        end
    end

    task automatic run_test(input int id, input string name, input logic req,
                            input logic toggle, input int rmode);
        int err0;
        err0          = errors;
        ready_mode    = rmode;
        toggle_en     = toggle;
        saw_src_stall = 1'b0;
        saw_switch    = 1'b0;
        if (!toggle) begin
            bypass_req <= req;
            do begin
                @(posedge axi4s_if_from_tx);
            end while (bypass_active != req);
        end
        for (int i = 0; i < test_beats[id]; i++) begin
            src_tvalid <= 1'b1;
            src_tdata  <= stim_data.pop_front();
            src_tkeep  <= stim_keep.pop_front();
            src_tlast  <= stim_last.pop_front();
            do begin
                @(posedge axi4s_if_from_tx);
            end while (!src_tready);
            // Occasional idle cycle between beats
            if (rand16() % 16'd4 == 0) begin
                src_tvalid <= 1'b0;
                @(posedge axi4s_if_from_tx);
            end
        end
        src_tvalid <= 1'b0;
        toggle_en = 1'b0;
        do begin
            @(posedge axi4s_if_from_tx);
        end while (exp_data.size() != 0);
        ready_mode = 0;
        assert (pkts_out == pkts_exp) else begin
            $display("Packet count differs, %0d expected and %0d received", pkts_exp, pkts_out);
            errors++;
        end
        if (id == 5) begin
            assert (saw_switch) else begin
                $display("bypass_active never changed while bypass_req toggled");
                errors++;
            end
        end
        if (id == 6) begin
            assert (saw_src_stall) else begin
                $display("src_tready never fell during a long dst stall");
                errors++;
            end
        end
        $display("test %0d %s: %0d errors", id, name, errors - err0);
    endtask

    initial begin
        aresetn    = 1'b0;
        bypass_req = 1'b0;
        src_tvalid = 1'b0;
        src_tdata  = '0;
        src_tkeep  = '0;
        src_tlast  = 1'b0;
        dst_tready = 1'b1;
        gen_packets(2, PKTS_PER_TEST, 1'b0);
        for (int t = 3; t <= 6; t++) begin
            gen_packets(t, PKTS_PER_TEST, 1'b1);
        end
        total_beats = stim_data.size();
        repeat (10) @(posedge axi4s_if_from_tx);
        aresetn <= 1'b1;
        // Idle outputs before any input
        repeat (5) begin
            @(posedge axi4s_if_from_tx);
            assert (!dst_tvalid && !bypass_active) else begin
                $display("ERROR dst_tvalid/bypass_active expected 0/0 got %h/%h",
                         dst_tvalid, bypass_active);
                errors++;
            end
        end
        $display("test 1 idle after reset: %0d errors", errors);
        run_test(2, "processing, plain packets", 1'b0, 1'b0, 0);
        run_test(3, "processing, empty last beats", 1'b0, 1'b0, 0);
        run_test(4, "bypass, empty last beats", 1'b1, 1'b0, 0);
        run_test(5, "random path switching", 1'b0, 1'b1, 1);
        run_test(6, "switching with long stalls", 1'b0, 1'b1, 2);
        $display("Summary: %0d beats checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (total_beats > 0);
        repeat (total_beats * 20 + 1000) @(posedge axi4s_if_from_tx);
        $display("Watchdog expired with %0d beats still expected", exp_data.size());
        $display("Test failed");
        $finish;
    end

endmodule : tb_stream_path

`default_nettype wire

//--- source/stream_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_path_top
    import axi4s_pkg::*;
    import path_pkg::*;
(
    input  wire logic   axi4s_if_from_tx,
    input  wire logic   aresetn,
    input  wire logic   bypass_req,

    input  wire logic   src_tvalid,
    output logic        src_tready,
    input  wire tdata_t src_tdata,
    input  wire tkeep_t src_tkeep,
    input  wire logic   src_tlast,

    output logic        dst_tvalid,
    input  wire logic   dst_tready,
    output tdata_t      dst_tdata,
    output tkeep_t      dst_tkeep,
    output logic        dst_tlast,

    output logic        bypass_active
);

    stream_if src_if ();
    stream_if dst_if ();
    stream_if to_proc_if ();
    stream_if adv_if ();
    stream_if proc_fwd_if ();
    stream_if from_proc_if ();

    // Entry at index 0 and exit at the far end
    stream_if byp_if [0:BYPASS_STAGES] ();

    logic process_empty;
    logic bypass_empty;

    assign src_if.tvalid = src_tvalid;
    assign src_if.tdata  = src_tdata;
    assign src_if.tkeep  = src_tkeep;
    assign src_if.tlast  = src_tlast;
    assign src_tready    = src_if.tready;

    assign dst_tvalid    = dst_if.tvalid;
    assign dst_tdata     = dst_if.tdata;
    assign dst_tkeep     = dst_if.tkeep;
    assign dst_tlast     = dst_if.tlast;
    assign dst_if.tready = dst_tready;

    path_select_fsm path_select_fsm_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass_req       (bypass_req),
        .src              (src_if),
        .to_process       (to_proc_if),
        .to_bypass        (byp_if[0]),
        .from_process     (from_proc_if),
        .from_bypass      (byp_if[BYPASS_STAGES]),
        .dst              (dst_if),
        .process_empty    (process_empty),
        .bypass_empty     (bypass_empty),
        .bypass_active    (bypass_active)
    );

    // Processing path
    tlast_advancer tlast_advancer_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .up               (to_proc_if),
        .down             (adv_if)
    );

    stream_fwd_stage proc_fwd_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .up               (adv_if),
        .down             (proc_fwd_if)
    );

    stream_ready_skid proc_skid_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .up               (proc_fwd_if),
        .down             (from_proc_if)
    );

    // Bypass path
    for (genvar i = 0; i < BYPASS_STAGES; i++) begin : g_bypass
        stream_fwd_stage byp_stage_inst (
            .axi4s_if_from_tx (axi4s_if_from_tx),
            .aresetn          (aresetn),
            .up               (byp_if[i]),
            .down             (byp_if[i+1])
        );
    end

    packet_counter process_counter_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .path_in          (to_proc_if),
        .path_out         (from_proc_if),
        .empty            (process_empty)
    );

    packet_counter bypass_counter_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .path_in          (byp_if[0]),
        .path_out         (byp_if[BYPASS_STAGES]),
        .empty            (bypass_empty)
    );

endmodule : stream_path_top

`default_nettype wire

//--- source/path_select_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module path_select_fsm
    import path_pkg::*;
(
    input wire logic axi4s_if_from_tx,
    input wire logic aresetn,
    input wire logic bypass_req,
    stream_if.rx     src,
    stream_if.tx     to_process,
    stream_if.tx     to_bypass,
    stream_if.rx     from_process,
    stream_if.rx     from_bypass,
    stream_if.tx     dst,
    input wire logic process_empty,
    input wire logic bypass_empty,
    output logic     bypass_active
);

    path_state_t state;
    path_state_t state_next;
    logic        in_packet;
    logic        src_hs;
    logic        open_next;

    assign src_hs = src.tvalid && src.tready;

    // Input packet still open after this cycle
    assign open_next = src_hs ? !src.tlast : in_packet;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            in_packet <= 1'b0;
            state     <= PROCESS;
        end else begin
            in_packet <= open_next;
            state     <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            PROCESS: begin
                if (bypass_req && !open_next) begin
                    state_next = DRAIN_TO_BYPASS;
                end
            end
            DRAIN_TO_BYPASS: begin
                // Request withdrawn before anything was steered
                if (!bypass_req) begin
                    state_next = PROCESS;
                end else if (process_empty) begin
                    state_next = BYPASS;
                end
            end
            BYPASS: begin
                if (!bypass_req && !open_next) begin
                    state_next = DRAIN_TO_PROCESS;
                end
            end
            DRAIN_TO_PROCESS: begin
                if (bypass_req) begin
                    state_next = BYPASS;
                end else if (bypass_empty) begin
                    state_next = PROCESS;
                end
            end
            default: begin
                state_next = PROCESS;
            end
        endcase
    end

    // Output follows the path that is being drained or is active
    assign bypass_active = (state == BYPASS) || (state == DRAIN_TO_PROCESS);

    // Input steering stalls while draining
    assign to_process.tvalid = src.tvalid && (state == PROCESS);
    assign to_process.tdata  = src.tdata;
    assign to_process.tkeep  = src.tkeep;
    assign to_process.tlast  = src.tlast;

    assign to_bypass.tvalid = src.tvalid && (state == BYPASS);
    assign to_bypass.tdata  = src.tdata;
    assign to_bypass.tkeep  = src.tkeep;
    assign to_bypass.tlast  = src.tlast;

    assign src.tready = (state == PROCESS) ? to_process.tready :
                        (state == BYPASS)  ? to_bypass.tready  : 1'b0;

    // Output selection
    assign dst.tvalid = bypass_active ? from_bypass.tvalid : from_process.tvalid;
    assign dst.tdata  = bypass_active ? from_bypass.tdata  : from_process.tdata;
    assign dst.tkeep  = bypass_active ? from_bypass.tkeep  : from_process.tkeep;
    assign dst.tlast  = bypass_active ? from_bypass.tlast  : from_process.tlast;

    assign from_process.tready = !bypass_active && dst.tready;
    assign from_bypass.tready  = bypass_active && dst.tready;

endmodule : path_select_fsm

`default_nettype wire

//--- source/packet_counter.sv
`timescale 1ns/1ps
`default_nettype none

module packet_counter
    import path_pkg::*;
(
    input wire logic axi4s_if_from_tx,
    input wire logic aresetn,
    stream_if.mon    path_in,
    stream_if.mon    path_out,
    output logic     empty
);

    logic [PKT_CNT_W-1:0] count;
    logic                 pkt_in;
    logic                 pkt_out;

    assign pkt_in  = path_in.tvalid && path_in.tready && path_in.tlast;
    assign pkt_out = path_out.tvalid && path_out.tready && path_out.tlast;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (pkt_in && !pkt_out) begin
            count <= count + 1'b1;
        end else if (pkt_out && !pkt_in) begin
            count <= count - 1'b1;
        end
    end

    assign empty = (count == '0);

endmodule : packet_counter

`default_nettype wire

//--- source/tlast_advancer.sv
`timescale 1ns/1ps
`default_nettype none

module tlast_advancer (
    input wire logic axi4s_if_from_tx,
    input wire logic aresetn,
    stream_if.rx     up,
    stream_if.tx     down
);

    stream_if held ();

    logic next_empty_last;
    logic skip;

    stream_fwd_stage hold_stage_inst (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .up               (up),
        .down             (held)
    );

    // Empty closing beat waiting at the input
    assign next_empty_last = up.tvalid && up.tlast && (up.tkeep == '0);

    // Masks the empty beat once it sits in the stage
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            skip <= 1'b0;
        end else if (next_empty_last && up.tready) begin
            skip <= 1'b1;
        end else if (skip && held.tvalid && held.tready) begin
            skip <= 1'b0;
        end
    end

    // A non-last beat waits for its successor since tlast may still move onto it
    assign down.tvalid = held.tvalid && !skip && (held.tlast || up.tvalid);
    assign down.tdata  = held.tdata;
    assign down.tkeep  = held.tkeep;
    assign down.tlast  = held.tlast || next_empty_last;

    // Skipped beat is dropped without waiting for the downstream
    assign held.tready = skip || (down.tvalid && down.tready);

endmodule : tlast_advancer

`default_nettype wire

//--- source/stream_ready_skid.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ready_skid
    import axi4s_pkg::*;
(
    input wire logic axi4s_if_from_tx,
    input wire logic aresetn,
    stream_if.rx     up,
    stream_if.tx     down
);

    logic   ready_q;
    logic   cap_valid;
    tdata_t cap_data;
    tkeep_t cap_keep;
    logic   cap_last;
    logic   capture;

    // Upstream only sees the registered ready
    assign up.tready = ready_q;

    // Beat accepted while the downstream has already stalled
    assign capture = up.tvalid && ready_q && !down.tready;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            ready_q   <= 1'b0;
            cap_valid <= 1'b0;
        end else begin
            ready_q <= down.tready;
            if (capture) begin
                cap_valid <= 1'b1;
            end else if (down.tready) begin
                cap_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (capture) begin
            cap_data <= up.tdata;
            cap_keep <= up.tkeep;
            cap_last <= up.tlast;
        end
    end

    // Captured beat goes first
    always_comb begin
        if (cap_valid) begin
            down.tvalid = 1'b1;
            down.tdata  = cap_data;
            down.tkeep  = cap_keep;
            down.tlast  = cap_last;
        end else begin
            down.tvalid = up.tvalid && ready_q;
            down.tdata  = up.tdata;
            down.tkeep  = up.tkeep;
            down.tlast  = up.tlast;
        end
    end

endmodule : stream_ready_skid

`default_nettype wire

//--- source/stream_fwd_stage.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fwd_stage
    import axi4s_pkg::*;
(
    input wire logic axi4s_if_from_tx,
    input wire logic aresetn,
    stream_if.rx     up,
    stream_if.tx     down
);

    logic   valid_q;
    tdata_t data_q;
    tkeep_t keep_q;
    logic   last_q;

    // Reload when empty or when the held beat leaves
    assign up.tready = !valid_q || down.tready;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (up.tready) begin
            valid_q <= up.tvalid;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (up.tvalid && up.tready) begin
            data_q <= up.tdata;
            keep_q <= up.tkeep;
            last_q <= up.tlast;
        end
    end

    assign down.tvalid = valid_q;
    assign down.tdata  = data_q;
    assign down.tkeep  = keep_q;
    assign down.tlast  = last_q;

endmodule : stream_fwd_stage

`default_nettype wire

//--- source/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stream_if
    import axi4s_pkg::*;
();

    logic   tvalid;
    logic   tready;
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;

    modport tx (
        output tvalid,
        input  tready,
        output tdata,
        output tkeep,
        output tlast
    );

    modport rx (
        input  tvalid,
        output tready,
        input  tdata,
        input  tkeep,
        input  tlast
    );

    // Passive observer
    modport mon (
        input  tvalid,
        input  tready,
        input  tdata,
        input  tkeep,
        input  tlast
    );

endinterface : stream_if

`default_nettype wire

//--- source/path_pkg.sv
`default_nettype none

package path_pkg;

    // Register slices in the bypass path
    localparam int BYPASS_STAGES = 2;

    // Up to 15 packets in flight per path
    localparam int PKT_CNT_W = 4;

    typedef enum logic [1:0] {
        PROCESS          = 2'd0,
        DRAIN_TO_BYPASS  = 2'd1,
        BYPASS           = 2'd2,
        DRAIN_TO_PROCESS = 2'd3
    } path_state_t;

endpackage : path_pkg

`default_nettype wire

//--- source/axi4s_pkg.sv
`default_nettype none

package axi4s_pkg;

    // Bytes carried by one stream beat
    localparam int DATA_BYTES = 4;

    // Beat payload with one byte per lane
    typedef logic [DATA_BYTES-1:0][7:0] tdata_t;

    // Byte enables with one bit per lane
    typedef logic [DATA_BYTES-1:0] tkeep_t;

endpackage : axi4s_pkg

`default_nettype wire
